// File: design/alu.sv
`default_nettype none

module alu (
  input  mipsPkg::aluOp_t aluOp,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [31:0]     result,
  output logic            zero
);

  import mipsPkg::*;

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);  // Signed compare for slt

  always_comb begin
    case (aluOp)
      ALU_ADD: begin
        result = a + b;  // Wraps without an overflow trap
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_SLT: begin
        result = {31'd0, lessThan};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Drives the beq decision in the memory stage
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/controlUnit.sv
`default_nettype none

module controlUnit (
  input  logic [31:0]     instruction,
  output mipsPkg::ctrl_t  ctrl,
  output mipsPkg::aluOp_t aluOp
);

  import mipsPkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instruction[31:26]);
  assign funct  = funct_t'(instruction[5:0]);

  always_comb begin
    ctrl  = '0;
    aluOp = ALU_ADD;
    case (opcode)
      RTYPE: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          F_ADD:   aluOp = ALU_ADD;
          F_SUB:   aluOp = ALU_SUB;
          F_AND:   aluOp = ALU_AND;
          F_OR:    aluOp = ALU_OR;
          F_SLT:   aluOp = ALU_SLT;
          default: ctrl  = '0;  // Includes the all-zero nop
        endcase
      end
      ADDI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      ANDI: begin
        ctrl.aluSrc     = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.zeroExtend = 1'b1;
        aluOp           = ALU_AND;
      end
      ORI: begin
        ctrl.aluSrc     = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.zeroExtend = 1'b1;
        aluOp           = ALU_OR;
      end
      LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      BEQ: begin
        ctrl.branch = 1'b1;
        aluOp       = ALU_SUB;  // Equal operands give zero
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/dataMemory.sv
`default_nettype none

module dataMemory #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic        Clk,
  input  logic        reset,
  input  logic [31:0] addr,
  input  logic [31:0] writeData,
  input  logic        memWrite,
  input  logic        memRead,
  output logic [31:0] readData
);

  localparam int IDX_W = $clog2(DMEM_DEPTH);

  logic [31:0]      mem [DMEM_DEPTH];
  logic [IDX_W-1:0] wordIdx;

  assign wordIdx  = addr[IDX_W+1:2];  // Byte address to word
  assign readData = memRead ? mem[wordIdx] : '0;

  always_ff @(posedge Clk) begin
    if (reset) begin
      mem <= '{default: '0};
    end else if (memWrite) begin
      mem[wordIdx] <= writeData;
    end
  end

  assert property (@(posedge Clk) disable iff (reset)
    (memRead || memWrite) |-> (addr[1:0] == 2'b00))
    else $error("unaligned data access at %h", addr);

endmodule

`default_nettype wire

// File: design/instructionFetch.sv
`default_nettype none

module instructionFetch #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic               Clk,
  input  logic               reset,
  input  mipsPkg::imemLoad_t imemLoad,
  input  logic               pcSrc,
  input  logic [31:0]        branchTarget,
  output mipsPkg::ifId_t     ifId
);

  localparam int IDX_W = $clog2(IMEM_DEPTH);
  localparam logic [31:0] LAST_PC = 32'((IMEM_DEPTH - 1) * 4);

  logic [31:0] imem [IMEM_DEPTH];
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] pcNext;
  logic [31:0] fetched;

  assign pcPlus4 = pc + 32'd4;
  assign fetched = imem[pc[IDX_W+1:2]];  // Word index

  // Fetch parks on the last word once the program runs out
  always_comb begin
    if (pcSrc) begin
      pcNext = branchTarget;
    end else if (pc == LAST_PC) begin
      pcNext = pc;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset && imemLoad.write) begin
      imem[imemLoad.addr[IDX_W-1:0]] <= imemLoad.data;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      pc         <= '0;
      ifId.valid <= 1'b0;
    end else begin
      pc               <= pcNext;
      ifId.pcPlus4     <= pcPlus4;
      ifId.instruction <= fetched;
      ifId.valid       <= !pcSrc;  // Taken branch squashes this fetch
    end
  end

  // Program is only written while the core is held in reset
  assert property (@(posedge Clk) imemLoad.write |-> reset)
    else $error("instruction memory load while core is running");

  // Redirects and sequential fetch stay inside the program memory
  assert property (@(posedge Clk) disable iff (reset)
    (pc[1:0] == 2'b00) && (pc <= LAST_PC))
    else $error("PC out of range or misaligned: %h", pc);

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // Primary opcode field in MIPS encoding
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    BEQ   = 6'h04,
    ADDI  = 6'h08,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    F_ADD = 6'h20,
    F_SUB = 6'h22,
    F_AND = 6'h24,
    F_OR  = 6'h25,
    F_SLT = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluOp_t;

  typedef struct packed {
    logic aluSrc;      // Immediate drives ALU operand b
    logic regDst;      // Destination is rd, else rt
    logic memRead;
    logic memWrite;
    logic memToReg;    // Writeback takes load data
    logic regWrite;
    logic branch;
    logic zeroExtend;  // Logical immediates
  } ctrl_t;

  typedef struct packed {
    logic [31:0] pcPlus4;
    logic [31:0] instruction;
    logic        valid;
  } ifId_t;

  typedef struct packed {
    ctrl_t       ctrl;
    aluOp_t      aluOp;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] pcPlus4;
    logic [31:0] immExt;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic        valid;
  } idEx_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] branchTarget;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic        zero;
    logic [4:0]  writeReg;
    logic        valid;
  } exMem_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] readData;
    logic [31:0] aluResult;
    logic [4:0]  writeReg;
    logic        valid;
  } memWb_t;

  // Program load port with a word address
  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [31:0] data;
  } imemLoad_t;

  // One record per architectural register write
  typedef struct packed {
    logic        valid;
    logic [4:0]  regNum;
    logic [31:0] data;
  } wbPacket_t;

endpackage

`default_nettype wire

// File: design/pipelineCpu.sv
`default_nettype none

module pipelineCpu #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic               Clk,
  input  logic               reset,
  input  mipsPkg::imemLoad_t imemLoad,
  output mipsPkg::wbPacket_t wb
);

  import mipsPkg::*;

  ifId_t  ifId;
  idEx_t  idEx;
  exMem_t exMem;
  memWb_t memWb;

  ctrl_t       decCtrl;
  aluOp_t      decAluOp;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [31:0] immExt;
  logic [31:0] readData1;
  logic [31:0] readData2;

  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] exBranchTarget;
  logic [4:0]  exWriteReg;

  logic        pcSrc;
  logic [31:0] memReadData;

  logic        wbRegWrite;
  logic [31:0] wbData;

  instructionFetch #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .Clk         (Clk),
    .reset       (reset),
    .imemLoad    (imemLoad),
    .pcSrc       (pcSrc),
    .branchTarget(exMem.branchTarget),
    .ifId        (ifId)
  );

  // Decode
  assign rs  = ifId.instruction[25:21];
  assign rt  = ifId.instruction[20:16];
  assign rd  = ifId.instruction[15:11];
  assign imm = ifId.instruction[15:0];
  assign immExt = decCtrl.zeroExtend ? {16'd0, imm} : {{16{imm[15]}}, imm};

  controlUnit u_ctrl (
    .instruction(ifId.instruction),
    .ctrl       (decCtrl),
    .aluOp      (decAluOp)
  );

  registerFile u_regs (
    .Clk      (Clk),
    .reset    (reset),
    .readReg1 (rs),
    .readReg2 (rt),
    .writeReg (memWb.writeReg),
    .writeData(wbData),
    .regWrite (wbRegWrite),
    .readData1(readData1),
    .readData2(readData2)
  );

  always_ff @(posedge Clk) begin
    if (reset) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.ctrl      <= decCtrl;
      idEx.aluOp     <= decAluOp;
      idEx.readData1 <= readData1;
      idEx.readData2 <= readData2;
      idEx.pcPlus4   <= ifId.pcPlus4;
      idEx.immExt    <= immExt;
      idEx.rt        <= rt;
      idEx.rd        <= rd;
      idEx.valid     <= ifId.valid && !pcSrc;
    end
  end

  // Execute
  assign aluB           = idEx.ctrl.aluSrc ? idEx.immExt : idEx.readData2;
  assign exWriteReg     = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
  assign exBranchTarget = idEx.pcPlus4 + {idEx.immExt[29:0], 2'b00};

  alu u_alu (
    .aluOp (idEx.aluOp),
    .a     (idEx.readData1),
    .b     (aluB),
    .result(aluResult),
    .zero  (aluZero)
  );

  // Decoder only ever hands a live instruction a defined operation
  assert property (@(posedge Clk) disable iff (reset)
    idEx.valid |-> (idEx.aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT}))
    else $error("undefined ALU operation in execute");

  always_ff @(posedge Clk) begin
    if (reset) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem.ctrl         <= idEx.ctrl;
      exMem.branchTarget <= exBranchTarget;
      exMem.aluResult    <= aluResult;
      exMem.storeData    <= idEx.readData2;
      exMem.zero         <= aluZero;
      exMem.writeReg     <= exWriteReg;
      exMem.valid        <= idEx.valid && !pcSrc;
    end
  end

  // Memory stage where beq resolves
  assign pcSrc = exMem.valid && exMem.ctrl.branch && exMem.zero;

  dataMemory #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
    .Clk      (Clk),
    .reset    (reset),
    .addr     (exMem.aluResult),
    .writeData(exMem.storeData),
    .memWrite (exMem.valid && exMem.ctrl.memWrite),
    .memRead  (exMem.valid && exMem.ctrl.memRead),
    .readData (memReadData)
  );

  always_ff @(posedge Clk) begin
    if (reset) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb.ctrl      <= exMem.ctrl;
      memWb.readData  <= memReadData;
      memWb.aluResult <= exMem.aluResult;
      memWb.writeReg  <= exMem.writeReg;
      memWb.valid     <= exMem.valid;  // beq itself retires normally
    end
  end

  // Writeback
  assign wbRegWrite = memWb.valid && memWb.ctrl.regWrite;
  assign wbData     = memWb.ctrl.memToReg ? memWb.readData : memWb.aluResult;
  assign wb = '{valid: wbRegWrite && (memWb.writeReg != 5'd0),
                regNum: memWb.writeReg,
                data: wbData};

endmodule

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile (
  input  logic        Clk,
  input  logic        reset,
  input  logic [4:0]  readReg1,
  input  logic [4:0]  readReg2,
  input  logic [4:0]  writeReg,
  input  logic [31:0] writeData,
  input  logic        regWrite,
  output logic [31:0] readData1,
  output logic [31:0] readData2
);

  logic [31:0] regs [32];

  // Write-first so decode sees the instruction now in writeback
  assign readData1 = (readReg1 == 5'd0) ? '0 :
                     (regWrite && writeReg == readReg1) ? writeData : regs[readReg1];
  assign readData2 = (readReg2 == 5'd0) ? '0 :
                     (regWrite && writeReg == readReg2) ? writeData : regs[readReg2];

  always_ff @(posedge Clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (regWrite && writeReg != 5'd0) begin
      regs[writeReg] <= writeData;
    end
  end

  // Storage for $zero never takes a write
  assert property (@(posedge Clk) disable iff (reset)
    (regWrite && writeReg == 5'd0) |=> (regs[0] == '0))
    else $error("register 0 changed after a write to it");

endmodule

`default_nettype wire

// File: tb.f
design/mipsPkg.sv
design/instructionFetch.sv
design/controlUnit.sv
design/registerFile.sv
design/alu.sv
design/dataMemory.sv
design/pipelineCpu.sv
test/cpuChecker.sv
test/cpuTb.sv

// File: test/cpuChecker.sv
`default_nettype none

module cpuChecker (
  input logic               Clk,
  input logic               reset,
  input mipsPkg::wbPacket_t wb
);

  timeunit 1ns;
  timeprecision 1ps;

  import mipsPkg::*;

  string       testName;
  logic [36:0] expQ [$];  // {reg, data} in program order
  logic [36:0] head;
  int          testErrors;
  int          seenCount;
  int          passCount;
  int          failCount;

  initial begin
    testName   = "none";
    testErrors = 0;
    seenCount  = 0;
    passCount  = 0;
    failCount  = 0;
  end

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = 0;
    seenCount  = 0;
    expQ.delete();
  endtask

  task automatic addExpected(input logic [4:0] r, input logic [31:0] d);
    expQ.push_back({r, d});
  endtask

  function automatic int pending();
    return expQ.size();
  endfunction

  task automatic finishTest();
    if (expQ.size() != 0) begin
      $display("%s: %0d writebacks missing at end of test", testName, expQ.size());
      testErrors++;
    end
    if (testErrors == 0) begin
      passCount++;
      $display("%s: ok, %0d writebacks matched", testName, seenCount);
    end else begin
      failCount++;
      $display("%s: %0d errors", testName, testErrors);
    end
  endtask

  // Sample mid-cycle once wb has settled after the rising edge
  always @(negedge Clk) begin
    if (!reset && wb.valid) begin
      seenCount++;
      if (expQ.size() == 0) begin
        $display("%s: unexpected writeback to r%0d = %h with nothing pending",
                 testName, wb.regNum, wb.data);
        testErrors++;
      end else begin
        head = expQ.pop_front();
        if (head !== {wb.regNum, wb.data}) begin
          $display("[FAIL] %s: expected r%0d = %h, actual r%0d = %h",
                   testName, head[36:32], head[31:0], wb.regNum, wb.data);
          testErrors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/cpuTb.sv
`default_nettype none

module cpuTb;

  timeunit 1ns;
  timeprecision 1ps;

  import mipsPkg::*;

  localparam int IMEM_DEPTH   = 64;
  localparam int DMEM_DEPTH   = 64;
  localparam int RESET_CYCLES = IMEM_DEPTH + 10;  // Program load plus hold
  localparam int NUM_RUNS     = 7;
  localparam longint WATCHDOG_NS = NUM_RUNS * (IMEM_DEPTH + RESET_CYCLES + 10) * 20;

  logic       Clk;
  logic       reset;
  imemLoad_t  imemLoad;
  wbPacket_t  wb;

  integer      seed;
  logic [31:0] prog [IMEM_DEPTH];
  int          progLen;
  int          recentDst [3];  // Destinations of the last three instructions
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [DMEM_DEPTH];
  funct_t      functList [5] = '{F_ADD, F_SUB, F_AND, F_OR, F_SLT};
  opcode_t     immOps [3] = '{ADDI, ANDI, ORI};

  pipelineCpu #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_dut (
    .Clk     (Clk),
    .reset   (reset),
    .imemLoad(imemLoad),
    .wb      (wb)
  );

  cpuChecker u_check (
    .Clk  (Clk),
    .reset(reset),
    .wb   (wb)
  );

  initial begin
    Clk = 1'b0;
    forever #10 Clk = ~Clk;
  end

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Source register that none of the last three instructions writes
  function automatic logic [4:0] pickSrc();
    int r;
    do begin
      r = rnd(16);
    end while (r != 0 && (r == recentDst[0] || r == recentDst[1] || r == recentDst[2]));
    return 5'(r);
  endfunction

  task automatic genProgram(input int kind, input int len);
    int          cls;
    int          dst;
    int          off;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] memOff;
    recentDst = '{0, 0, 0};
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      prog[i] = 32'd0;  // Padding nops
    end
    for (int i = 0; i < len; i++) begin
      case (kind)
        0:       cls = (i < 6) ? 1 : 0;
        1:       cls = 1;
        2:       cls = (i < 6) ? 1 : 2 + rnd(2);
        3:       cls = (i < 6) ? 1 : ((rnd(3) == 0) ? 4 : rnd(2));
        default: cls = (i < 4) ? 1 : rnd(5);
      endcase
      dst    = (kind == 1 && rnd(6) == 0) ? 0 : 1 + rnd(15);
      rs     = pickSrc();
      rt     = pickSrc();
      memOff = 16'(4 * (rnd(2) ? rnd(8) : rnd(DMEM_DEPTH)));
      case (cls)
        0: prog[i] = {RTYPE, rs, rt, 5'(dst), 5'd0, functList[rnd(5)]};
        1: prog[i] = {(kind == 0) ? ADDI : immOps[rnd(3)], rs, 5'(dst), 16'($random(seed))};
        2: prog[i] = {LW, 5'd0, 5'(dst), memOff};
        3: prog[i] = {SW, 5'd0, rt, memOff};
        default: begin
          off = rnd(4);
          if (i + 1 + off > len) off = len - i - 1;  // Target stays inside program or padding
          prog[i] = {BEQ, rs, rnd(2) ? rs : rt, 16'(off)};
        end
      endcase
      if (cls == 3 || cls == 4) dst = 0;
      recentDst[2] = recentDst[1];
      recentDst[1] = recentDst[0];
      recentDst[0] = dst;
    end
    progLen = len;
  endtask

  // Sequential ISA model; slots counts fetch cycles including branch bubbles
  task automatic runModel(output int slots);
    int          pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] res;
    int          dst;
    modelRegs = '{default: '0};
    modelMem  = '{default: '0};
    pc    = 0;
    slots = 0;
    while (pc < progLen) begin
      w    = prog[pc];
      a    = modelRegs[w[25:21]];
      b    = modelRegs[w[20:16]];
      sext = {{16{w[15]}}, w[15:0]};
      dst  = -1;
      pc++;
      slots++;
      case (w[31:26])
        RTYPE: begin
          dst = w[15:11];
          case (w[5:0])
            F_ADD:   res = a + b;
            F_SUB:   res = a - b;
            F_AND:   res = a & b;
            F_OR:    res = a | b;
            F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: dst = -1;  // Nop
          endcase
        end
        ADDI: begin
          dst = w[20:16];
          res = a + sext;
        end
        ANDI: begin
          dst = w[20:16];
          res = a & {16'd0, w[15:0]};
        end
        ORI: begin
          dst = w[20:16];
          res = a | {16'd0, w[15:0]};
        end
        LW: begin
          dst = w[20:16];
          res = modelMem[(a + sext) / 4];
        end
        SW: modelMem[(a + sext) / 4] = b;
        BEQ: begin
          if (a == b) begin
            pc    = pc + int'($signed(sext));
            slots = slots + 3;
          end
        end
        default: dst = -1;
      endcase
      if (dst > 0) begin
        modelRegs[dst] = res;
        u_check.addExpected(5'(dst), res);
      end
    end
  endtask

  task automatic runTest(input string name, input int kind, input int len);
    int slots;
    int cycles;
    genProgram(kind, len);
    u_check.beginTest(name);
    runModel(slots);
    @(posedge Clk);
    reset <= 1'b1;
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      @(posedge Clk);
      imemLoad <= '{write: 1'b1, addr: 8'(a), data: prog[a]};
    end
    @(posedge Clk);
    imemLoad <= '0;
    repeat (10) @(posedge Clk);
    reset <= 1'b0;
    // Last instruction retires four edges after its fetch slot
    cycles = 0;
    while ((u_check.pending() != 0 || cycles < slots + 6) && cycles < slots + 12) begin
      @(posedge Clk);
      cycles++;
    end
    u_check.finishTest();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed = 32'haeed_b87b;
    reset    <= 1'b1;
    imemLoad <= '0;
    runTest("aluOps", 0, 24);
    runTest("immediates", 1, 24);
    runTest("loadStore", 2, 28);
    runTest("branches", 3, 32);
    for (int k = 0; k < 3; k++) begin
      runTest("mixed", 4, 40);  // Fresh reset before each program
    end
    $display("Summary: %0d tests passed, %0d tests failed",
             u_check.passCount, u_check.failCount);
    if (u_check.failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
